// File: compile.f
+incdir+logic
logic/mpf_pkg.sv
logic/mpf_req_fifo.sv
logic/mpf_shim_buffer_afu.sv
logic/mpf_shim_cfg_regs.sv
logic/mpf_req_forward.sv
logic/mpf_shim_top.sv
test/tb_clock_gen.sv
test/tb_mpf_shim.sv

// File: run_sim.sh
#!/bin/sh
# Builds the shim testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_mpf_shim -f compile.f -o sim_mpf_shim \
    > build.log 2>&1 \
    && ./obj_dir/sim_mpf_shim > sim.log 2>&1 \
    && grep -qx "test passed" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: test/tb_mpf_shim.sv
// ========================================================================
// Directed testbench for the request shim with queue reference model,
// host-side monitor, watchdog and closing summary
// ========================================================================

`include "mpf_defs.svh"

module tb_mpf_shim;

    timeunit 1ns;
    timeprecision 1ps;

    import mpf_pkg::*;

    localparam int NUM_TESTS = 6;
    // Buffered requests at which the AFU almost-full level comes up
    localparam int FILL = `MPF_BUF_ENTRIES - `MPF_ALMOST_FULL_THRESHOLD;

    logic                      clk;
    logic                      arst_n;
    logic                      cfg_wr_en;
    logic                      cfg_addr;
    logic [`MPF_ADDR_BITS-1:0] cfg_wr_data;
    t_c0_tx                    afu_c0_tx;
    t_c1_tx                    afu_c1_tx;
    logic                      afu_c0_alm_full;
    logic                      afu_c1_alm_full;
    t_c0_rx                    afu_c0_rx;
    t_c1_rx                    afu_c1_rx;
    t_c0_tx                    host_c0_tx;
    t_c1_tx                    host_c1_tx;
    logic                      host_c0_alm_full;
    logic                      host_c1_alm_full;
    t_c0_rx                    host_c0_rx;
    t_c1_rx                    host_c1_rx;

    // Reference model, one queue of expected host requests per channel
    t_rd_hdr                   exp_c0[$];
    t_wr_req                   exp_c1[$];
    t_rd_hdr                   front_c0;
    t_wr_req                   front_c1;
    logic [`MPF_ADDR_BITS-1:0] model_base;
    int                        num_checks   = 0;
    int                        value_errors = 0;
    int                        other_errors = 0;

    tb_clock_gen
    #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    )
    u_clock_gen
    (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mpf_shim_top
    #(
        .ENABLE_C0_BYPASS (1'b1)
    )
    u_mpf_shim_top
    (
        .clk              (clk),
        .arst_n           (arst_n),
        .cfg_wr_en        (cfg_wr_en),
        .cfg_addr         (cfg_addr),
        .cfg_wr_data      (cfg_wr_data),
        .afu_c0_tx        (afu_c0_tx),
        .afu_c1_tx        (afu_c1_tx),
        .afu_c0_alm_full  (afu_c0_alm_full),
        .afu_c1_alm_full  (afu_c1_alm_full),
        .afu_c0_rx        (afu_c0_rx),
        .afu_c1_rx        (afu_c1_rx),
        .host_c0_tx       (host_c0_tx),
        .host_c1_tx       (host_c1_tx),
        .host_c0_alm_full (host_c0_alm_full),
        .host_c1_alm_full (host_c1_alm_full),
        .host_c0_rx       (host_c0_rx),
        .host_c1_rx       (host_c1_rx)
    );

    // ====================================================================
    // Helpers
    // ====================================================================

    task automatic report_mismatch(input string name, input string got, input string exp);
        $display("error at %0t ns: %s is 0x%s, expected 0x%s", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        num_checks++;
        if (got !== exp)
            report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    function automatic t_rd_hdr pick_read_hdr();
        t_rd_hdr     h;
        logic [31:0] r;
        r       = $urandom;
        h.addr  = $urandom;
        h.mdata = r[`MPF_MDATA_BITS-1:0];
        return h;
    endfunction

    function automatic t_wr_req make_write_req();
        t_wr_req     w;
        logic [31:0] r;
        r       = $urandom;
        w.addr  = $urandom;
        w.mdata = r[`MPF_MDATA_BITS-1:0];
        w.data  = {$urandom, $urandom};
        return w;
    endfunction

    // One AFU cycle on both channels, each issued request goes to the model
    // with the base that the shim is expected to add
    task automatic drive_cycle(input logic c0_valid, input t_rd_hdr hdr,
                               input logic c1_valid, input t_wr_req req);
        t_rd_hdr exp_hdr;
        t_wr_req exp_req;
        @(posedge clk);
        afu_c0_tx.rd_valid <= c0_valid;
        afu_c0_tx.hdr      <= hdr;
        afu_c1_tx.wr_valid <= c1_valid;
        afu_c1_tx.req      <= req;
        exp_hdr      = hdr;
        exp_hdr.addr = hdr.addr + model_base;
        exp_req      = req;
        exp_req.addr = req.addr + model_base;
        if (c0_valid)
            exp_c0.push_back(exp_hdr);
        if (c1_valid)
            exp_c1.push_back(exp_req);
    endtask

    // Address 0 is the base, address 1 the pause word
    task automatic write_cfg(input logic addr, input logic [`MPF_ADDR_BITS-1:0] data);
        @(posedge clk);
        cfg_wr_en   <= 1'b1;
        cfg_addr    <= addr;
        cfg_wr_data <= data;
        @(posedge clk);
        cfg_wr_en <= 1'b0;
        if (!addr)
            model_base = data;
    endtask

    // Idles the AFU and waits until the host has shown every expected request
    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        drive_cycle(1'b0, '0, 1'b0, '0);
        while ((exp_c0.size() != 0 || exp_c1.size() != 0) && waited < max_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_c0.size() != 0 || exp_c1.size() != 0)
        begin
            $display("drain timed out after %0d cycles with %0d reads and %0d writes missing",
                     waited, exp_c0.size(), exp_c1.size());
            other_errors++;
        end
    endtask

    // ====================================================================
    // Host-side monitor, compares every host request with the model
    // ====================================================================

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (arst_n === 1'b1 && host_c0_tx.rd_valid)
            begin
                if (exp_c0.size() == 0)
                begin
                    $display("unexpected host read at %0t ns with nothing outstanding", $time);
                    other_errors++;
                end
                else
                begin
                    front_c0 = exp_c0.pop_front();
                    num_checks++;
                    if (host_c0_tx.hdr !== front_c0)
                        report_mismatch("host_c0_tx.hdr", $sformatf("%h", host_c0_tx.hdr),
                                        $sformatf("%h", front_c0));
                end
            end
            if (arst_n === 1'b1 && host_c1_tx.wr_valid)
            begin
                if (exp_c1.size() == 0)
                begin
                    $display("unexpected host write at %0t ns with nothing outstanding", $time);
                    other_errors++;
                end
                else
                begin
                    front_c1 = exp_c1.pop_front();
                    num_checks++;
                    if (host_c1_tx.req !== front_c1)
                        report_mismatch("host_c1_tx.req", $sformatf("%h", host_c1_tx.req),
                                        $sformatf("%h", front_c1));
                end
            end
        end
    end

    // ====================================================================
    // Directed tests
    // ====================================================================

    task automatic reset_state();
        @(negedge clk);
        check_bit("host_c0_tx.rd_valid", host_c0_tx.rd_valid, 1'b0);
        check_bit("host_c1_tx.wr_valid", host_c1_tx.wr_valid, 1'b0);
        check_bit("afu_c0_alm_full", afu_c0_alm_full, 1'b0);
        check_bit("afu_c1_alm_full", afu_c1_alm_full, 1'b0);
    endtask

    // A read before any configuration write sees the reset base of zero
    task automatic read_forwarding();
        drive_cycle(1'b1, pick_read_hdr(), 1'b0, '0);
        wait_drain(20);
        write_cfg(1'b0, 32'h0004_0000);
        // Bypass takes a lone read straight into the host register
        drive_cycle(1'b1, pick_read_hdr(), 1'b0, '0);
        @(negedge clk);
        check_bit("host_c0_tx.rd_valid", host_c0_tx.rd_valid, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        check_bit("host_c0_tx.rd_valid", host_c0_tx.rd_valid, 1'b1);
        repeat (5) drive_cycle(1'b1, pick_read_hdr(), 1'b0, '0);
        wait_drain(50);
    endtask

    // Writes pass the FIFO, so a lone write shows up two cycles later
    task automatic write_forwarding();
        write_cfg(1'b0, 32'h00a0_0000);
        drive_cycle(1'b0, '0, 1'b1, make_write_req());
        @(negedge clk);
        check_bit("host_c1_tx.wr_valid", host_c1_tx.wr_valid, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        check_bit("host_c1_tx.wr_valid", host_c1_tx.wr_valid, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        check_bit("host_c1_tx.wr_valid", host_c1_tx.wr_valid, 1'b1);
        repeat (4) drive_cycle(1'b0, '0, 1'b1, make_write_req());
        wait_drain(50);
    endtask

    task automatic read_pause_hold();
        write_cfg(1'b1, 32'h1);
        // Level stays low until the last of the fill requests is stored
        for (int i = 0; i < FILL; i++)
        begin
            drive_cycle(1'b1, pick_read_hdr(), 1'b0, '0);
            @(negedge clk);
            check_bit("afu_c0_alm_full", afu_c0_alm_full, 1'b0);
        end
        repeat (6)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0);
            @(negedge clk);
            check_bit("afu_c0_alm_full", afu_c0_alm_full, 1'b1);
            check_bit("host_c0_tx.rd_valid", host_c0_tx.rd_valid, 1'b0);
        end
        write_cfg(1'b1, 32'h0);
        wait_drain(50);
        @(negedge clk);
        check_bit("afu_c0_alm_full", afu_c0_alm_full, 1'b0);
    endtask

    task automatic write_backpressure();
        int   sent;
        int   tries;
        logic go;
        @(posedge clk);
        host_c1_alm_full <= 1'b1;
        for (int i = 0; i < FILL + 6; i++)
        begin
            drive_cycle(1'b0, '0, (i < FILL), make_write_req());
            @(negedge clk);
            check_bit("host_c1_tx.wr_valid", host_c1_tx.wr_valid, 1'b0);
        end
        check_bit("afu_c1_alm_full", afu_c1_alm_full, 1'b1);
        @(posedge clk);
        host_c1_alm_full <= 1'b0;
        // More writes follow while the backlog drains, each one waiting on
        // the AFU almost-full level
        sent  = 0;
        tries = 0;
        while (sent < 4 && tries < 100)
        begin
            @(negedge clk);
            go = !afu_c1_alm_full;
            drive_cycle(1'b0, '0, go, make_write_req());
            if (go)
                sent++;
            tries++;
        end
        if (sent < 4)
        begin
            $display("AFU write channel stayed almost full after the host released it");
            other_errors++;
        end
        wait_drain(50);
        // A duplicated write would reach the monitor with an empty queue
        repeat (5) drive_cycle(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        check_bit("afu_c1_alm_full", afu_c1_alm_full, 1'b0);
    endtask

    task automatic response_passthrough();
        t_c0_rx      rx0;
        t_c1_rx      rx1;
        logic [31:0] r;
        for (int i = 0; i < 8; i++)
        begin
            r         = $urandom;
            rx0.valid = r[0];
            rx0.mdata = r[8 +: `MPF_MDATA_BITS];
            rx0.data  = {$urandom, $urandom};
            rx1.valid = r[1];
            rx1.mdata = r[16 +: `MPF_MDATA_BITS];
            @(posedge clk);
            host_c0_rx <= rx0;
            host_c1_rx <= rx1;
            @(negedge clk);
            num_checks++;
            if (afu_c0_rx !== rx0)
                report_mismatch("afu_c0_rx", $sformatf("%h", afu_c0_rx), $sformatf("%h", rx0));
            num_checks++;
            if (afu_c1_rx !== rx1)
                report_mismatch("afu_c1_rx", $sformatf("%h", afu_c1_rx), $sformatf("%h", rx1));
        end
        @(posedge clk);
        host_c0_rx <= '0;
        host_c1_rx <= '0;
    endtask

    // AFU decides on the level it saw in the cycle before each edge
    task automatic mixed_traffic();
        logic [31:0] r;
        logic        go0;
        logic        go1;
        write_cfg(1'b0, $urandom);
        for (int i = 0; i < 400; i++)
        begin
            @(negedge clk);
            r   = $urandom;
            go0 = !afu_c0_alm_full && r[0];
            go1 = !afu_c1_alm_full && r[1];
            drive_cycle(go0, pick_read_hdr(), go1, make_write_req());
            host_c0_alm_full <= (r[3:2] == 2'b00);
            host_c1_alm_full <= (r[5:4] == 2'b00);
        end
        @(posedge clk);
        host_c0_alm_full <= 1'b0;
        host_c1_alm_full <= 1'b0;
        wait_drain(200);
    endtask

    // ====================================================================
    // Run control
    // ====================================================================

    initial
    begin
        cfg_wr_en        <= 1'b0;
        cfg_addr         <= 1'b0;
        cfg_wr_data      <= '0;
        afu_c0_tx        <= '0;
        afu_c1_tx        <= '0;
        host_c0_alm_full <= 1'b0;
        host_c1_alm_full <= 1'b0;
        host_c0_rx       <= '0;
        host_c1_rx       <= '0;
        model_base = '0;
        void'($urandom(32'h2774700b));

        @(posedge arst_n);
        reset_state();
        read_forwarding();
        write_forwarding();
        read_pause_hold();
        write_backpressure();
        response_passthrough();
        mixed_traffic();

        $display("summary: %0d checks, %0d value errors, %0d other errors",
                 num_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Each test gets 2000 clock periods of budget
    initial
    begin
        #(NUM_TESTS * 2000 * 10);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000 * 10);
        $display("test failed");
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
// ========================================================================
// Testbench clock and reset source
// ========================================================================

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset leaves on a rising edge once the hold time is over
    initial
    begin
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: logic/mpf_shim_top.sv
// ========================================================================
// Top of the request shim with buffer, configuration and forwarder
// ========================================================================

`include "mpf_defs.svh"

module mpf_shim_top
#(
    parameter bit ENABLE_C0_BYPASS = 1'b0
)
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_wr_en,
    input  logic                      cfg_addr,
    input  logic [`MPF_ADDR_BITS-1:0] cfg_wr_data,
    input  mpf_pkg::t_c0_tx           afu_c0_tx,
    input  mpf_pkg::t_c1_tx           afu_c1_tx,
    output logic                      afu_c0_alm_full,
    output logic                      afu_c1_alm_full,
    output mpf_pkg::t_c0_rx           afu_c0_rx,
    output mpf_pkg::t_c1_rx           afu_c1_rx,
    output mpf_pkg::t_c0_tx           host_c0_tx,
    output mpf_pkg::t_c1_tx           host_c1_tx,
    input  logic                      host_c0_alm_full,
    input  logic                      host_c1_alm_full,
    input  mpf_pkg::t_c0_rx           host_c0_rx,
    input  mpf_pkg::t_c1_rx           host_c1_rx
);

    import mpf_pkg::*;

    t_c0_tx    buf_c0_tx;
    t_c1_tx    buf_c1_tx;
    logic      deq_c0;
    logic      deq_c1;
    t_shim_cfg cfg;

    // Responses come back with no flow control, so they go straight through
    assign afu_c0_rx = host_c0_rx;
    assign afu_c1_rx = host_c1_rx;

    mpf_shim_buffer_afu
    #(
        .ENABLE_C0_BYPASS (ENABLE_C0_BYPASS)
    )
    u_buffer
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .afu_c0_tx   (afu_c0_tx),
        .afu_c1_tx   (afu_c1_tx),
        .deq_c0      (deq_c0),
        .deq_c1      (deq_c1),
        .buf_c0_tx   (buf_c0_tx),
        .buf_c1_tx   (buf_c1_tx),
        .c0_alm_full (afu_c0_alm_full),
        .c1_alm_full (afu_c1_alm_full)
    );

    mpf_shim_cfg_regs u_cfg_regs
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg         (cfg)
    );

    mpf_req_forward u_forward
    (
        .clk              (clk),
        .arst_n           (arst_n),
        .cfg              (cfg),
        .buf_c0_tx        (buf_c0_tx),
        .buf_c1_tx        (buf_c1_tx),
        .host_c0_alm_full (host_c0_alm_full),
        .host_c1_alm_full (host_c1_alm_full),
        .deq_c0           (deq_c0),
        .deq_c1           (deq_c1),
        .host_c0_tx       (host_c0_tx),
        .host_c1_tx       (host_c1_tx)
    );

endmodule

// File: logic/mpf_req_forward.sv
// ========================================================================
// Forwarder from the AFU buffers to the host port
// Dequeue under back-pressure and pause, address rebase, one register stage
// ========================================================================

module mpf_req_forward
(
    input  logic               clk,
    input  logic               arst_n,
    input  mpf_pkg::t_shim_cfg cfg,
    input  mpf_pkg::t_c0_tx    buf_c0_tx,
    input  mpf_pkg::t_c1_tx    buf_c1_tx,
    input  logic               host_c0_alm_full,
    input  logic               host_c1_alm_full,
    output logic               deq_c0,
    output logic               deq_c1,
    output mpf_pkg::t_c0_tx    host_c0_tx,
    output mpf_pkg::t_c1_tx    host_c1_tx
);

    import mpf_pkg::*;

    // ====================================================================
    // Dequeue decision
    // ====================================================================

    // The host accepts everything it is given, so its almost-full level
    // and the pause bit are the only things that hold a request back
    assign deq_c0 = buf_c0_tx.rd_valid && !host_c0_alm_full && !cfg.pause_c0;
    assign deq_c1 = buf_c1_tx.wr_valid && !host_c1_alm_full && !cfg.pause_c1;

    // ====================================================================
    // Host register stage
    // ====================================================================

    // Payload is loaded on a dequeue and is meaningful only while valid is set
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            host_c0_tx <= '0;
            host_c1_tx <= '0;
        end
        else
        begin
            host_c0_tx.rd_valid <= deq_c0;
            host_c1_tx.wr_valid <= deq_c1;
            if (deq_c0)
            begin
                host_c0_tx.hdr.addr  <= buf_c0_tx.hdr.addr + cfg.addr_base;
                host_c0_tx.hdr.mdata <= buf_c0_tx.hdr.mdata;
            end
            if (deq_c1)
            begin
                host_c1_tx.req.addr  <= buf_c1_tx.req.addr + cfg.addr_base;
                host_c1_tx.req.mdata <= buf_c1_tx.req.mdata;
                host_c1_tx.req.data  <= buf_c1_tx.req.data;
            end
        end
    end

    // Only a request that is really at the head may be consumed
    a_deq_needs_head: assert property (
        @(posedge clk) disable iff (!arst_n)
        (deq_c0 |-> buf_c0_tx.rd_valid) and (deq_c1 |-> buf_c1_tx.wr_valid)
    ) else $error("dequeue without a valid buffered request");

    // The buffer must hold a head that was not taken, bypass included
    a_c0_head_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        buf_c0_tx.rd_valid && !deq_c0 |=> buf_c0_tx.rd_valid && $stable(buf_c0_tx.hdr)
    ) else $error("read request left the buffer without a dequeue");

    a_c1_head_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        buf_c1_tx.wr_valid && !deq_c1 |=> buf_c1_tx.wr_valid && $stable(buf_c1_tx.req)
    ) else $error("write request left the buffer without a dequeue");

endmodule

// File: logic/mpf_shim_cfg_regs.sv
// ========================================================================
// Write-only configuration registers for address base and pause bits
// ========================================================================

`include "mpf_defs.svh"

module mpf_shim_cfg_regs
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_wr_en,
    input  logic                      cfg_addr,
    input  logic [`MPF_ADDR_BITS-1:0] cfg_wr_data,
    output mpf_pkg::t_shim_cfg        cfg
);

    import mpf_pkg::*;

    logic [`MPF_ADDR_BITS-1:0] addr_base_q;
    // Bit 0 holds channel 0, bit 1 holds channel 1
    logic [1:0]                pause_q;

    // Address 0 is the base, address 1 the pause word
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            addr_base_q <= '0;
            pause_q     <= '0;
        end
        else if (cfg_wr_en)
        begin
            if (!cfg_addr)
                addr_base_q <= cfg_wr_data;
            else
                pause_q <= cfg_wr_data[1:0];
        end
    end

    always_comb
    begin
        cfg.addr_base = addr_base_q;
        cfg.pause_c0  = pause_q[0];
        cfg.pause_c1  = pause_q[1];
    end

    // A write with undriven address or data would corrupt the live setup
    a_cfg_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        cfg_wr_en |-> !$isunknown({cfg_addr, cfg_wr_data})
    ) else $error("configuration write with unknown address or data");

endmodule

// File: logic/mpf_shim_buffer_afu.sv
// ========================================================================
// AFU-side request buffers for reads and writes with explicit dequeue
// Optional same-cycle bypass of the read buffer when it is empty
// ========================================================================

`include "mpf_defs.svh"

module mpf_shim_buffer_afu
#(
    parameter bit ENABLE_C0_BYPASS = 1'b0
)
(
    input  logic            clk,
    input  logic            arst_n,
    input  mpf_pkg::t_c0_tx afu_c0_tx,
    input  mpf_pkg::t_c1_tx afu_c1_tx,
    input  logic            deq_c0,
    input  logic            deq_c1,
    output mpf_pkg::t_c0_tx buf_c0_tx,
    output mpf_pkg::t_c1_tx buf_c1_tx,
    output logic            c0_alm_full,
    output logic            c1_alm_full
);

    import mpf_pkg::*;

    // Requests wait here until the forwarder takes them, so the rest of
    // the shim is free of any fixed latency toward the AFU

    // ====================================================================
    // Channel 0, reads
    // ====================================================================

    t_rd_hdr c0_first;
    logic    c0_not_empty;
    logic    c0_enq;
    logic    c0_deq;

    generate
        if (ENABLE_C0_BYPASS)
        begin : g_c0_bypass
            always_comb
            begin
                // An empty FIFO shows the incoming request directly
                if (c0_not_empty)
                begin
                    buf_c0_tx.rd_valid = 1'b1;
                    buf_c0_tx.hdr      = c0_first;
                end
                else
                begin
                    buf_c0_tx = afu_c0_tx;
                end

                // Store the request only when it was not taken on the spot
                c0_enq = afu_c0_tx.rd_valid && (c0_not_empty || !deq_c0);
                c0_deq = deq_c0 && c0_not_empty;
            end
        end
        else
        begin : g_c0_fifo_only
            always_comb
            begin
                // Every read goes through the FIFO
                buf_c0_tx.rd_valid = c0_not_empty;
                buf_c0_tx.hdr      = c0_first;
                c0_enq             = afu_c0_tx.rd_valid;
                c0_deq             = deq_c0;
            end
        end
    endgenerate

    mpf_req_fifo
    #(
        .T_DATA    (t_rd_hdr),
        .N_ENTRIES (`MPF_BUF_ENTRIES),
        .THRESHOLD (`MPF_ALMOST_FULL_THRESHOLD)
    )
    u_c0_fifo
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .enq_data    (afu_c0_tx.hdr),
        .enq_en      (c0_enq),
        .deq_en      (c0_deq),
        .first       (c0_first),
        .not_empty   (c0_not_empty),
        .almost_full (c0_alm_full)
    );

    // ====================================================================
    // Channel 1, writes
    // ====================================================================

    t_wr_req c1_first;
    logic    c1_not_empty;

    // No bypass here, the mux on the full write payload is not worth it
    always_comb
    begin
        buf_c1_tx.wr_valid = c1_not_empty;
        buf_c1_tx.req      = c1_first;
    end

    mpf_req_fifo
    #(
        .T_DATA    (t_wr_req),
        .N_ENTRIES (`MPF_BUF_ENTRIES),
        .THRESHOLD (`MPF_ALMOST_FULL_THRESHOLD)
    )
    u_c1_fifo
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .enq_data    (afu_c1_tx.req),
        .enq_en      (afu_c1_tx.wr_valid),
        .deq_en      (deq_c1),
        .first       (c1_first),
        .not_empty   (c1_not_empty),
        .almost_full (c1_alm_full)
    );

endmodule

// File: logic/mpf_req_fifo.sv
// ========================================================================
// Request FIFO with a payload type parameter and registered almost-full
// ========================================================================

`include "mpf_defs.svh"

module mpf_req_fifo
#(
    parameter type T_DATA    = logic,
    parameter int  N_ENTRIES = `MPF_BUF_ENTRIES,
    parameter int  THRESHOLD = `MPF_ALMOST_FULL_THRESHOLD
)
(
    input  logic  clk,
    input  logic  arst_n,
    input  T_DATA enq_data,
    input  logic  enq_en,
    input  logic  deq_en,
    output T_DATA first,
    output logic  not_empty,
    output logic  almost_full
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Storage is payload only, the occupancy counter says what is live
    T_DATA               mem [N_ENTRIES];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] count_next;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] nxt;
        nxt = (ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    always_comb
    begin
        case ({enq_en, deq_en})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= (N_ENTRIES <= THRESHOLD);
        end
        else
        begin
            if (enq_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (deq_en)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count_next;
            // Looking at the next count lets the level move on the same edge
            // as the occupancy, so the AFU sees it one cycle after the request
            almost_full <= (N_ENTRIES - int'(count_next)) <= THRESHOLD;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    // Head is read straight out of storage
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // A full FIFO may only take a new entry while the head leaves
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        enq_en |-> (int'(count) < N_ENTRIES) || deq_en
    ) else $error("enqueue into a full request FIFO");

    a_no_deq_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        deq_en |-> not_empty
    ) else $error("dequeue from an empty request FIFO");

endmodule

// File: logic/mpf_pkg.sv
// ========================================================================
// Packed struct types for requests, responses and shim configuration
// ========================================================================

`include "mpf_defs.svh"

package mpf_pkg;

    // ====================================================================
    // Request payloads
    // ====================================================================

    // Read header, the only payload a read request carries
    typedef struct packed {
        logic [`MPF_ADDR_BITS-1:0]  addr;
        logic [`MPF_MDATA_BITS-1:0] mdata;
    } t_rd_hdr;

    // Write request with its line of data
    typedef struct packed {
        logic [`MPF_ADDR_BITS-1:0]  addr;
        logic [`MPF_MDATA_BITS-1:0] mdata;
        logic [`MPF_DATA_BITS-1:0]  data;
    } t_wr_req;

    // ====================================================================
    // Channel wires
    // ====================================================================

    // Channel 0 carries reads, qualified by a single strobe
    typedef struct packed {
        logic    rd_valid;
        t_rd_hdr hdr;
    } t_c0_tx;

    // Channel 1 carries writes
    typedef struct packed {
        logic    wr_valid;
        t_wr_req req;
    } t_c1_tx;

    // Read response returns the tag with the line data
    typedef struct packed {
        logic                       valid;
        logic [`MPF_MDATA_BITS-1:0] mdata;
        logic [`MPF_DATA_BITS-1:0]  data;
    } t_c0_rx;

    // Write response is only the tag
    typedef struct packed {
        logic                       valid;
        logic [`MPF_MDATA_BITS-1:0] mdata;
    } t_c1_rx;

    // ====================================================================
    // Configuration
    // ====================================================================

    // Base added to every forwarded address, plus a hold bit per channel
    typedef struct packed {
        logic [`MPF_ADDR_BITS-1:0] addr_base;
        logic                      pause_c0;
        logic                      pause_c1;
    } t_shim_cfg;

endpackage

// File: logic/mpf_defs.svh
// ========================================================================
// Size macros shared by the memory-properties request shim
// Line address, data and tag widths, buffer depth and almost-full slack
// ========================================================================

`ifndef MPF_DEFS_SVH
`define MPF_DEFS_SVH

// Width of a cache line address on both request channels
`define MPF_ADDR_BITS 32

// Width of write data and of read response data
`define MPF_DATA_BITS 64

// Width of the tag that comes back with every response
`define MPF_MDATA_BITS 8

// Almost-full rises once this many slots or fewer remain free
`define MPF_ALMOST_FULL_THRESHOLD 4

// Default buffer depth, two slots beyond the in-flight slack
`define MPF_BUF_ENTRIES (`MPF_ALMOST_FULL_THRESHOLD + 2)

`endif
